/* pe_pkg.sv */
`default_nettype none

package pe_pkg;

    // Lane operand and partial-sum widths.
    localparam int DWD     = 8;
    localparam int PSUMDWD = 16;

    // Lanes per row.
    localparam int PE_ROW  = 4;

    // Row sum keeps two guard bits for four lanes.
    localparam int SUMDWD  = 18;

    // Tile counter width.
    localparam int TILEWD  = 4;

    typedef enum logic [1:0] {
        XNOR = 2'd0,
        INT2 = 2'd1,
        INT4 = 2'd2,
        INT8 = 2'd3
    } prec_mode_e;

    // D16 packs two 8-bit partial sums in one word.
    typedef enum logic {
        D8  = 1'b0,
        D16 = 1'b1
    } psum_mode_e;

    typedef struct packed {
        psum_mode_e psum_mode;
        logic       psum_parity;
    } fs_ctl_t;

    typedef struct packed {
        prec_mode_e          mode;
        logic [TILEWD-1:0]   inum_t;
        logic [TILEWD-1:0]   wnum_t;
    } ms_conf_t;

    typedef struct packed {
        ms_conf_t            conf;
        logic [DWD-1:0]      mask;
    } ms_ctl_t;

    typedef struct packed {
        logic [DWD-1:0]      inp;
        logic [DWD-1:0]      wgt;
        logic [PSUMDWD-1:0]  psum;
    } lane_in_t;

    // Same layout, psum already half-selected.
    typedef struct packed {
        logic [DWD-1:0]      inp;
        logic [DWD-1:0]      wgt;
        logic [PSUMDWD-1:0]  psum;
    } lane_fs_t;

    typedef struct packed {
        logic [PSUMDWD-1:0]  psum;
    } lane_out_t;

endpackage

`default_nettype wire

/* pe_fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_fetch_stage (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire pe_pkg::fs_ctl_t    i_ctl,
    input  wire                     i_main_rdy,
    output logic                    o_main_ack,
    output logic                    o_fs_rdy,
    input  wire                     i_fs_ack,
    input  wire pe_pkg::lane_in_t   i_data [pe_pkg::PE_ROW],
    input  wire pe_pkg::ms_conf_t   i_conf,
    output pe_pkg::lane_fs_t        o_data [pe_pkg::PE_ROW],
    output pe_pkg::ms_ctl_t         o_ms_ctl
);

    logic                       rdy_q;
    logic                       load;
    logic [pe_pkg::DWD-1:0]     mask;
    logic [pe_pkg::PSUMDWD-1:0] psum_sel [pe_pkg::PE_ROW];

    // Operand mask from precision mode.
    always_comb begin
        unique case (i_conf.mode)
            pe_pkg::XNOR: mask = {{(pe_pkg::DWD-1){1'b0}}, 1'b1};
            pe_pkg::INT2: mask = {{(pe_pkg::DWD-2){1'b0}}, 2'b11};
            pe_pkg::INT4: mask = {{(pe_pkg::DWD-4){1'b0}}, 4'hf};
            default:      mask = '1;
        endcase
    end

    // Upper half only in packed mode with parity set.
    always_comb begin
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            if (i_ctl.psum_mode == pe_pkg::D16 && i_ctl.psum_parity) begin
                psum_sel[i] = i_data[i].psum >> pe_pkg::DWD;
            end else begin
                psum_sel[i] = i_data[i].psum;
            end
        end
    end

    // Ready for input once out of reset and output slot frees up.
    assign o_main_ack = !i_rst && (!rdy_q || i_fs_ack);
    assign load       = i_main_rdy && o_main_ack;
    assign o_fs_rdy   = rdy_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rdy_q <= 1'b0;
        end else if (load) begin
            rdy_q <= 1'b1;
        end else if (i_fs_ack) begin
            rdy_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ms_ctl <= '0;
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                o_data[i] <= '0;
            end
        end else if (load) begin
            o_ms_ctl.conf <= i_conf;
            o_ms_ctl.mask <= mask;
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                o_data[i].inp  <= i_data[i].inp;
                o_data[i].wgt  <= i_data[i].wgt;
                o_data[i].psum <= psum_sel[i];
            end
        end
    end

endmodule

`default_nettype wire

/* pe_mac_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_mac_stage (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_fs_rdy,
    output logic                    o_fs_ack,
    output logic                    o_ms_rdy,
    input  wire                     i_ms_ack,
    input  wire pe_pkg::lane_fs_t   i_data [pe_pkg::PE_ROW],
    input  wire pe_pkg::ms_ctl_t    i_ms_ctl,
    output pe_pkg::lane_out_t       o_psum [pe_pkg::PE_ROW],
    output pe_pkg::ms_conf_t        o_conf
);

    logic                              rdy_q;
    logic                              load;
    logic signed [pe_pkg::DWD-1:0]     op_a [pe_pkg::PE_ROW];
    logic signed [pe_pkg::DWD-1:0]     op_b [pe_pkg::PE_ROW];
    logic signed [pe_pkg::PSUMDWD-1:0] prod [pe_pkg::PE_ROW];
    logic [pe_pkg::PSUMDWD-1:0]        sum  [pe_pkg::PE_ROW];

    // Mask the operand and extend from the mask's top bit.
    function automatic logic [pe_pkg::DWD-1:0] ext_op(
        input logic [pe_pkg::DWD-1:0] val,
        input logic [pe_pkg::DWD-1:0] mask
    );
        logic [pe_pkg::DWD-1:0] top;
        logic                   sign;
        top  = mask & ~(mask >> 1);
        sign = |(val & top);
        return (val & mask) | (sign ? ~mask : '0);
    endfunction

    always_comb begin
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            op_a[i] = ext_op(i_data[i].inp, i_ms_ctl.mask);
            op_b[i] = ext_op(i_data[i].wgt, i_ms_ctl.mask);
            if (i_ms_ctl.conf.mode == pe_pkg::XNOR) begin
                // +1 on match, -1 otherwise.
                if (op_a[i][0] == op_b[i][0]) begin
                    prod[i] = pe_pkg::PSUMDWD'(1);
                end else begin
                    prod[i] = '1;
                end
            end else begin
                prod[i] = op_a[i] * op_b[i];
            end
            // Wraps at 16 bits.
            sum[i] = i_data[i].psum + prod[i];
        end
    end

    assign o_fs_ack = !rdy_q || i_ms_ack;
    assign load     = i_fs_rdy && o_fs_ack;
    assign o_ms_rdy = rdy_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rdy_q <= 1'b0;
        end else if (load) begin
            rdy_q <= 1'b1;
        end else if (i_ms_ack) begin
            rdy_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_conf <= '0;
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                o_psum[i] <= '0;
            end
        end else if (load) begin
            o_conf <= i_ms_ctl.conf;
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                o_psum[i].psum <= sum[i];
            end
        end
    end

endmodule

`default_nettype wire

/* pe_accum_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_accum_stage (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_ms_rdy,
    output logic                    o_ms_ack,
    output logic                    o_res_rdy,
    input  wire                     i_res_ack,
    input  wire pe_pkg::lane_out_t  i_psum [pe_pkg::PE_ROW],
    input  wire pe_pkg::ms_conf_t   i_conf,
    output pe_pkg::lane_out_t       o_psum [pe_pkg::PE_ROW],
    output logic [pe_pkg::SUMDWD-1:0] o_row_sum,
    output pe_pkg::ms_conf_t        o_conf
);

    logic                             rdy_q;
    logic                             load;
    logic signed [pe_pkg::SUMDWD-1:0] row_sum;

    // Lane psums are signed, extend before adding.
    always_comb begin
        row_sum = '0;
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            row_sum = row_sum + pe_pkg::SUMDWD'($signed(i_psum[i].psum));
        end
    end

    assign o_ms_ack  = !rdy_q || i_res_ack;
    assign load      = i_ms_rdy && o_ms_ack;
    assign o_res_rdy = rdy_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rdy_q <= 1'b0;
        end else if (load) begin
            rdy_q <= 1'b1;
        end else if (i_res_ack) begin
            rdy_q <= 1'b0;
        end
    end

    // Config rides along so results map back to their tile.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_conf    <= '0;
            o_row_sum <= '0;
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                o_psum[i] <= '0;
            end
        end else if (load) begin
            o_conf    <= i_conf;
            o_row_sum <= row_sum;
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                o_psum[i] <= i_psum[i];
            end
        end
    end

endmodule

`default_nettype wire

/* pe_row_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_row_top (
    input  wire                       i_clk,
    input  wire                       i_rst,
    input  wire pe_pkg::fs_ctl_t      i_ctl,
    input  wire pe_pkg::ms_conf_t     i_conf,
    input  wire                       i_main_rdy,
    output logic                      o_main_ack,
    input  wire pe_pkg::lane_in_t     i_data [pe_pkg::PE_ROW],
    output logic                      o_res_rdy,
    input  wire                       i_res_ack,
    output pe_pkg::lane_out_t         o_psum [pe_pkg::PE_ROW],
    output logic [pe_pkg::SUMDWD-1:0] o_row_sum,
    output pe_pkg::ms_conf_t          o_conf
);

    // Fetch to MAC.
    logic               fs_rdy;
    logic               fs_ack;
    pe_pkg::lane_fs_t   fs_data [pe_pkg::PE_ROW];
    pe_pkg::ms_ctl_t    fs_ms_ctl;

    // MAC to accumulate.
    logic               ms_rdy;
    logic               ms_ack;
    pe_pkg::lane_out_t  ms_psum [pe_pkg::PE_ROW];
    pe_pkg::ms_conf_t   ms_conf;

    pe_fetch_stage u_fetch (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ctl      (i_ctl),
        .i_main_rdy (i_main_rdy),
        .o_main_ack (o_main_ack),
        .o_fs_rdy   (fs_rdy),
        .i_fs_ack   (fs_ack),
        .i_data     (i_data),
        .i_conf     (i_conf),
        .o_data     (fs_data),
        .o_ms_ctl   (fs_ms_ctl)
    );

    pe_mac_stage u_mac (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_fs_rdy   (fs_rdy),
        .o_fs_ack   (fs_ack),
        .o_ms_rdy   (ms_rdy),
        .i_ms_ack   (ms_ack),
        .i_data     (fs_data),
        .i_ms_ctl   (fs_ms_ctl),
        .o_psum     (ms_psum),
        .o_conf     (ms_conf)
    );

    pe_accum_stage u_accum (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ms_rdy   (ms_rdy),
        .o_ms_ack   (ms_ack),
        .o_res_rdy  (o_res_rdy),
        .i_res_ack  (i_res_ack),
        .i_psum     (ms_psum),
        .i_conf     (ms_conf),
        .o_psum     (o_psum),
        .o_row_sum  (o_row_sum),
        .o_conf     (o_conf)
    );

endmodule

`default_nettype wire

/* pe_row_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_row_checker (
    input wire                        i_clk,
    input wire                        i_rst,
    input wire                        o_main_ack,
    input wire                        o_res_rdy,
    input wire                        i_res_ack,
    input wire pe_pkg::lane_out_t     o_psum [pe_pkg::PE_ROW],
    input wire [pe_pkg::SUMDWD-1:0]   o_row_sum,
    input wire pe_pkg::ms_conf_t      o_conf
);

    int unsigned fail_count = 0;

    // A stalled result keeps rdy, sum and config.
    a_res_hold: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_res_rdy && !i_res_ack |=> o_res_rdy && $stable(o_row_sum) && $stable(o_conf)
    ) else begin
        $error("result handshake or sum changed during a stall");
        fail_count++;
    end

    // Lane psums hold as well.
    for (genvar i = 0; i < pe_pkg::PE_ROW; i++) begin : g_lane
        a_psum_hold: assert property (
            @(posedge i_clk) disable iff (i_rst)
            o_res_rdy && !i_res_ack |=> $stable(o_psum[i].psum)
        ) else begin
            $error("lane %0d psum changed during a stall", i);
            fail_count++;
        end
    end

    a_no_ack_in_reset: assert property (
        @(posedge i_clk) i_rst |-> !o_main_ack
    ) else begin
        $error("input acknowledged while in reset");
        fail_count++;
    end

    a_rdy_low_after_reset: assert property (
        @(posedge i_clk) i_rst |=> !o_res_rdy
    ) else begin
        $error("result ready raised right after reset");
        fail_count++;
    end

endmodule

bind pe_row_top pe_row_checker u_checker (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .o_main_ack (o_main_ack),
    .o_res_rdy  (o_res_rdy),
    .i_res_ack  (i_res_ack),
    .o_psum     (o_psum),
    .o_row_sum  (o_row_sum),
    .o_conf     (o_conf)
);

`default_nettype wire

/* tb_pe_row.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pe_row;

    typedef pe_pkg::lane_in_t [pe_pkg::PE_ROW-1:0] lanes_t;

    typedef struct packed {
        logic [pe_pkg::PE_ROW-1:0][pe_pkg::PSUMDWD-1:0] psum;
        logic [pe_pkg::SUMDWD-1:0]                      row_sum;
        pe_pkg::ms_conf_t                               conf;
    } result_t;

    logic                      i_clk;
    logic                      i_rst;
    pe_pkg::fs_ctl_t           i_ctl;
    pe_pkg::ms_conf_t          i_conf;
    logic                      i_main_rdy;
    logic                      o_main_ack;
    pe_pkg::lane_in_t          i_data [pe_pkg::PE_ROW];
    logic                      o_res_rdy;
    logic                      i_res_ack;
    pe_pkg::lane_out_t         o_psum [pe_pkg::PE_ROW];
    logic [pe_pkg::SUMDWD-1:0] o_row_sum;
    pe_pkg::ms_conf_t          o_conf;

    result_t     exp_q [$];
    logic        stall_en;
    int unsigned cycles;
    int unsigned cycle_limit;

    pe_row_top u_dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ctl      (i_ctl),
        .i_conf     (i_conf),
        .i_main_rdy (i_main_rdy),
        .o_main_ack (o_main_ack),
        .i_data     (i_data),
        .o_res_rdy  (o_res_rdy),
        .i_res_ack  (i_res_ack),
        .o_psum     (o_psum),
        .o_row_sum  (o_row_sum),
        .o_conf     (o_conf)
    );

    always #2 i_clk = ~i_clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Operand of width w, sign-extended.
    function automatic int sext(input logic [7:0] val, input int w);
        int r;
        r = int'(val) & ((1 << w) - 1);
        if (r >= (1 << (w - 1))) begin
            r = r - (1 << w);
        end
        return r;
    endfunction

    function automatic result_t expected_result(input pe_pkg::fs_ctl_t ctl,
                                                input pe_pkg::ms_conf_t conf,
                                                input lanes_t lanes);
        result_t     e;
        int          w;
        int          prod;
        int          total;
        logic [15:0] sel;
        case (conf.mode)
            pe_pkg::XNOR: w = 1;
            pe_pkg::INT2: w = 2;
            pe_pkg::INT4: w = 4;
            default:      w = 8;
        endcase
        total = 0;
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            sel = lanes[i].psum;
            if (ctl.psum_mode == pe_pkg::D16 && ctl.psum_parity) begin
                sel = {8'h00, lanes[i].psum[15:8]};
            end
            if (conf.mode == pe_pkg::XNOR) begin
                prod = (lanes[i].inp[0] == lanes[i].wgt[0]) ? 1 : -1;
            end else begin
                prod = sext(lanes[i].inp, w) * sext(lanes[i].wgt, w);
            end
            e.psum[i] = 16'(int'(sel) + prod);
            total = total + int'($signed(e.psum[i]));
        end
        e.row_sum = 18'(total);
        e.conf    = conf;
        return e;
    endfunction

    function automatic pe_pkg::fs_ctl_t make_ctl(input pe_pkg::psum_mode_e m, input logic p);
        pe_pkg::fs_ctl_t c;
        c.psum_mode   = m;
        c.psum_parity = p;
        return c;
    endfunction

    function automatic pe_pkg::ms_conf_t make_conf(input pe_pkg::prec_mode_e m,
                                                   input logic [3:0] inum,
                                                   input logic [3:0] wnum);
        pe_pkg::ms_conf_t c;
        c.mode   = m;
        c.inum_t = inum;
        c.wnum_t = wnum;
        return c;
    endfunction

    // Upper operand bits always set so the mask has work to do.
    function automatic lanes_t random_lanes();
        lanes_t l;
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            l[i].inp  = 8'($urandom) | 8'h30;
            l[i].wgt  = 8'($urandom) | 8'hc0;
            l[i].psum = 16'($urandom);
        end
        return l;
    endfunction

    function automatic lanes_t const_lanes(input logic [7:0] inp, input logic [7:0] wgt,
                                           input logic [15:0] psum);
        lanes_t l;
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            l[i].inp  = inp;
            l[i].wgt  = wgt;
            l[i].psum = psum;
        end
        return l;
    endfunction

    // Call on a rising edge; returns on the edge that takes the item.
    task automatic send_item(input pe_pkg::fs_ctl_t ctl, input pe_pkg::ms_conf_t conf,
                             input lanes_t lanes);
        i_ctl      <= ctl;
        i_conf     <= conf;
        i_main_rdy <= 1'b1;
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            i_data[i] <= lanes[i];
        end
        do begin
            @(posedge i_clk);
        end while (!o_main_ack);
        i_main_rdy <= 1'b0;
    endtask

    task automatic wait_drain();
        @(posedge i_clk);
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
        end
    endtask

    task automatic test_reset_and_single();
        int lat;
        check_value("o_res_rdy", o_res_rdy, 0);
        check_value("o_row_sum", o_row_sum, 0);
        send_item(make_ctl(pe_pkg::D8, 1'b0), make_conf(pe_pkg::INT8, 4'd1, 4'd2),
                  random_lanes());
        lat = 0;
        do begin
            @(posedge i_clk);
            lat++;
        end while (!o_res_rdy);
        check_value("latency", lat, 3);
        wait_drain();
    endtask

    task automatic test_prec_modes();
        for (int m = 0; m < 4; m++) begin
            for (int k = 0; k < 4; k++) begin
                send_item(make_ctl(pe_pkg::D8, 1'b0),
                          make_conf(pe_pkg::prec_mode_e'(m), 4'(k), 4'(m)), random_lanes());
            end
        end
        wait_drain();
    endtask

    task automatic test_psum_half();
        for (int k = 0; k < 6; k++) begin
            send_item(make_ctl((k < 4) ? pe_pkg::D16 : pe_pkg::D8, 1'(k % 2)),
                      make_conf(pe_pkg::INT4, 4'(k), 4'd0), random_lanes());
        end
        wait_drain();
    endtask

    task automatic test_stall_stream();
        stall_en <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            send_item(make_ctl(pe_pkg::psum_mode_e'($urandom % 2), 1'($urandom)),
                      make_conf(pe_pkg::prec_mode_e'($urandom % 4), 4'($urandom),
                                4'($urandom)), random_lanes());
        end
        wait_drain();
        stall_en <= 1'b0;
    endtask

    task automatic test_conf_passthrough();
        for (int k = 0; k < 8; k++) begin
            send_item(make_ctl(pe_pkg::D8, 1'b0),
                      make_conf(pe_pkg::prec_mode_e'(k % 4), 4'(k), 4'(15 - k)),
                      random_lanes());
        end
        wait_drain();
    endtask

    task automatic test_wrap();
        pe_pkg::fs_ctl_t  ctl;
        pe_pkg::ms_conf_t conf;
        ctl  = make_ctl(pe_pkg::D8, 1'b0);
        conf = make_conf(pe_pkg::INT8, 4'd3, 4'd5);
        send_item(ctl, conf, const_lanes(8'h7f, 8'h7f, 16'h7fff));
        send_item(ctl, conf, const_lanes(8'h80, 8'h7f, 16'h8000));
        // Most negative row sum.
        send_item(ctl, conf, const_lanes(8'h00, 8'h00, 16'h8000));
        send_item(ctl, conf, const_lanes(8'h01, 8'h01, 16'hffff));
        wait_drain();
    endtask

    always @(posedge i_clk) begin
        if (stall_en) begin
            i_res_ack <= ($urandom % 3) != 0;
        end else begin
            i_res_ack <= 1'b1;
        end
    end

    // Scoreboard, output side first.
    always @(posedge i_clk) begin : scoreboard
        result_t e;
        lanes_t  cur;
        if (!i_rst && o_res_rdy && i_res_ack) begin
            if (exp_q.size() == 0) begin
                fail_run("Result handed out with no input item pending");
            end
            e = exp_q.pop_front();
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                check_value($sformatf("o_psum[%0d]", i), o_psum[i].psum, e.psum[i]);
            end
            check_value("o_row_sum", o_row_sum, e.row_sum);
            check_value("o_conf", o_conf, e.conf);
        end
        if (!i_rst && i_main_rdy && o_main_ack) begin
            for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
                cur[i] = i_data[i];
            end
            exp_q.push_back(expected_result(i_ctl, i_conf, cur));
        end
    end

    always @(posedge i_clk) begin
        if (u_dut.u_checker.fail_count != 0) begin
            fail_run("A bound assertion on the DUT failed");
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_run("Simulation hung: cycle limit reached before the tests finished");
        end
    end

    initial begin
        void'($urandom(32'h0a134879));
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_ctl      = '0;
        i_conf     = '0;
        i_main_rdy = 1'b0;
        i_res_ack  = 1'b1;
        stall_en   = 1'b0;
        cycles     = 0;
        for (int i = 0; i < pe_pkg::PE_ROW; i++) begin
            i_data[i] = '0;
        end
        // Per transfer budget over all tests, plus slack.
        cycle_limit = 20 * (1 + 16 + 6 + 40 + 8 + 4) + 200;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        test_reset_and_single();
        test_prec_modes();
        test_psum_half();
        test_stall_stream();
        test_conf_passthrough();
        test_wrap();
        // Idle edges so a stray extra result still reaches the scoreboard.
        repeat (4) @(posedge i_clk);
        if (exp_q.size() == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Results pending or assertions failed at the end of the run");
            $display("TEST FAIL");
            $fatal(1, "run failed");
        end
    end

endmodule

`default_nettype wire

/* pe_row.f */
pe_pkg.sv
pe_fetch_stage.sv
pe_mac_stage.sv
pe_accum_stage.sv
pe_row_top.sv
pe_row_checker.sv
tb_pe_row.sv

/* Bender.yml */
package:
  name: pe_row

sources:
  # Package first, then the stages, then the top level.
  - files:
      - pe_pkg.sv
      - pe_fetch_stage.sv
      - pe_mac_stage.sv
      - pe_accum_stage.sv
      - pe_row_top.sv

  # Simulation only.
  - target: test
    files:
      - pe_row_checker.sv
      - tb_pe_row.sv
